/* verilog.f */
+incdir+.
design/boot_pkg.sv
design/boot_sequencer.sv
design/cfg_loader.sv
design/io_router.sv
design/boot_mem.sv
design/cfg_regs.sv
design/boot_top.sv
sim/boot_sva.sv
sim/boot_tb.sv

/* Bender.yml */
package:
  name: boot_load

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - design/boot_pkg.sv
      - design/boot_sequencer.sv
      - design/cfg_loader.sv
      - design/io_router.sv
      - design/boot_mem.sv
      - design/cfg_regs.sv
      - design/boot_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - sim/boot_sva.sv
      - sim/boot_tb.sv

/* sim/boot_tb.sv */
/*
 * Boot-load subsystem testbench
 * Drives the host port through the load, config and run phases
 * and checks every read against a model of both address spaces.
 */
`timescale 1ns/1ns
`include "boot_settings.svh"

module boot_tb;

   import boot_pkg::*;

   // Memory clear plus worst-case transactions, doubled as margin
   localparam int MAX_TXN     = 150;
   localparam int TXN_CYC     = 15;
   localparam int TIMEOUT_CYC = 2 * (`BOOT_MEM_WORDS + MAX_TXN * TXN_CYC);

   // Three loader writes of about six cycles each
   localparam int CFG_WAIT_CYC = 60;

   logic   clk;
   logic   rst;
   logic   host_req;
   io_op_e host_op;
   addr_t  host_addr;
   word_t  host_wdata;
   logic   host_ack;
   word_t  host_rdata;
   logic   done;
   logic   freeze;
   word_t  core_id;
   word_t  boot_pc;

   word_t       mem_model [`BOOT_MEM_WORDS];
   logic        freeze_model;
   word_t       core_id_model;
   word_t       boot_pc_model;
   logic [31:0] lcg_state;
   addr_t       written_q [$];
   string       cur_test;
   int          cyc_cnt   = 0;
   int          err_cnt   = 0;
   int          test_errs = 0;
   int          check_cnt = 0;
   int          test_cnt  = 0;

   boot_top i_dut
     (.clk_i(clk), .rst_i(rst),
      .host_req_i(host_req), .host_op_i(host_op), .host_addr_i(host_addr),
      .host_wdata_i(host_wdata), .host_ack_o(host_ack), .host_rdata_o(host_rdata),
      .done_o(done), .freeze_o(freeze), .core_id_o(core_id), .boot_pc_o(boot_pc));

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cyc_cnt++;
      if (cyc_cnt >= TIMEOUT_CYC)
      begin
         $display("Timeout: run stopped after %0d cycles in test %s", cyc_cnt, cur_test);
         $display("Simulation FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Memory space only, all eleven low bits random
   function automatic addr_t rand_mem_addr();
      logic [31:0] r;
      r = lcg_next();
      return {1'b0, r[26:16]};
   endfunction

   // Expected read value of either space
   function automatic word_t ref_read(addr_t addr);
      if (addr[`BOOT_ADDR_W-1])
      begin
         case (addr[`BOOT_ADDR_W-2:0])
            0:       return word_t'(freeze_model);
            1:       return core_id_model;
            2:       return boot_pc_model;
            default: return '0;
         endcase
      end
      return mem_model[addr % `BOOT_MEM_WORDS];
   endfunction

   task automatic model_write(addr_t addr, word_t data);
      if (addr[`BOOT_ADDR_W-1])
      begin
         case (addr[`BOOT_ADDR_W-2:0])
            0:       freeze_model = data[0];
            1:       core_id_model = data;
            2:       boot_pc_model = data;
            default: ;
         endcase
      end
      else
         mem_model[addr % `BOOT_MEM_WORDS] = data;
   endtask

   task automatic check_word(string what, word_t exp, word_t act);
      check_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         test_errs++;
         $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic check_bit(string what, logic exp, logic act);
      check_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         test_errs++;
         $display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
      end
   endtask

   // One four-phase cycle on the host port
   task automatic host_xfer(io_op_e op, addr_t addr, word_t wdata, output word_t rdata);
      @(posedge clk);
      #1;
      host_req   = 1'b1;
      host_op    = op;
      host_addr  = addr;
      host_wdata = wdata;
      do
      begin
         @(posedge clk);
         #1;
      end
      while (!host_ack);
      rdata    = host_rdata;
      host_req = 1'b0;
      while (host_ack)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic host_write(addr_t addr, word_t data);
      word_t rd;
      host_xfer(OP_WRITE, addr, data, rd);
      model_write(addr, data);
   endtask

   task automatic host_read_check(string what, addr_t addr);
      word_t rd;
      host_xfer(OP_READ, addr, '0, rd);
      check_word(what, ref_read(addr), rd);
   endtask

   task automatic begin_test(string name);
      cur_test  = name;
      test_errs = 0;
      test_cnt++;
   endtask

   task automatic end_test();
      if (test_errs == 0)
         $display("test %-12s ok", cur_test);
      else
         $display("test %-12s %0d errors", cur_test, test_errs);
   endtask

   initial
   begin
      word_t       rd;
      addr_t       a;
      logic [31:0] r;
      int          n;
      rst        = 1'b1;
      host_req   = 1'b0;
      host_op    = OP_READ;
      host_addr  = '0;
      host_wdata = '0;
      lcg_state  = 32'd21860;
      freeze_model  = 1'b1;
      core_id_model = '0;
      boot_pc_model = '0;
      for (int i = 0; i < `BOOT_MEM_WORDS; i++)
         mem_model[i] = '0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;

      begin_test("reset");
      check_bit("done_o", 1'b0, done);
      check_bit("freeze_o", 1'b1, freeze);
      check_word("core_id_o", '0, core_id);
      check_word("boot_pc_o", '0, boot_pc);
      end_test();

      begin_test("zero_fill");
      host_read_check("first word", 12'h000);
      host_read_check("last word", 12'h0ff);
      repeat (6) host_read_check("random word", rand_mem_addr());
      end_test();

      begin_test("mem_random");
      repeat (100)
      begin
         r = lcg_next();
         if (r[16] || written_q.size() == 0)
         begin
            a = rand_mem_addr();
            host_write(a, lcg_next());
            written_q.push_back(a);
         end
         else
         begin
            // Other upper bits, same memory word
            a = written_q[r[23:8] % written_q.size()];
            a[`BOOT_ADDR_W-2:8] = r[30:28];
            host_read_check("written word", a);
         end
      end
      end_test();

      begin_test("finish");
      host_xfer(OP_FINISH, '0, '0, rd);
      n = 0;
      while (!done && n < CFG_WAIT_CYC)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      freeze_model  = 1'b0;
      core_id_model = word_t'(`BOOT_CORE_ID);
      boot_pc_model = word_t'(`BOOT_PC);
      check_bit("done_o", 1'b1, done);
      check_bit("freeze_o", 1'b0, freeze);
      check_word("core_id_o", word_t'(`BOOT_CORE_ID), core_id);
      check_word("boot_pc_o", word_t'(`BOOT_PC), boot_pc);
      host_read_check("core id reg", 12'h801);
      host_read_check("boot pc reg", 12'h802);
      host_read_check("unmapped reg", 12'h805);
      end_test();

      begin_test("run");
      for (int i = 0; i < 8 && i < written_q.size(); i++)
         host_read_check("kept word", written_q[i]);
      host_write(12'h800, 32'd1);
      host_read_check("freeze reg", 12'h800);
      check_bit("freeze_o", 1'b1, freeze);
      host_xfer(OP_FINISH, '0, '0, rd);
      check_bit("done_o", 1'b1, done);
      check_bit("freeze_o", 1'b1, freeze);
      check_word("core_id_o", core_id_model, core_id);
      check_word("boot_pc_o", boot_pc_model, boot_pc);
      host_read_check("word after finish", written_q[0]);
      end_test();

      $display("tests %0d, checks %0d, errors %0d, assertion errors %0d",
               test_cnt, check_cnt, err_cnt, i_dut.i_sva.err_cnt);
      if (err_cnt == 0 && i_dut.i_sva.err_cnt == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

/* sim/boot_sva.sv */
/*
 * Boot-load handshake assertions
 * Four-phase rules on the host, memory, config and loader
 * ports, and done staying high once set.
 */
`timescale 1ns/1ns

module boot_sva
  (input logic              clk_i,
   input logic              rst_i,
   input logic              host_req_i,
   input boot_pkg::io_op_e  host_op_i,
   input boot_pkg::addr_t   host_addr_i,
   input boot_pkg::word_t   host_wdata_i,
   input logic              host_ack_i,
   input logic              done_i,
   input logic              mem_req_i,
   input logic              mem_ack_i,
   input logic              cr_req_i,
   input logic              cr_ack_i,
   input logic              ld_req_i,
   input logic              ld_ack_i,
   input boot_pkg::addr_t   ld_addr_i,
   input boot_pkg::word_t   ld_wdata_i
   );

   int unsigned err_cnt = 0;

   // Ack is set on an edge where req was high
   property ack_needs_req(logic req, logic ack);
      @(posedge clk_i) disable iff (rst_i) $rose(ack) |-> $past(req);
   endproperty

   property req_held_to_ack(logic req, logic ack);
      @(posedge clk_i) disable iff (rst_i) $fell(req) |-> ack;
   endproperty

   a_host_ack: assert property (ack_needs_req(host_req_i, host_ack_i))
   else
   begin
      $error("host ack rose without req");
      err_cnt++;
   end
   a_mem_ack: assert property (ack_needs_req(mem_req_i, mem_ack_i))
   else
   begin
      $error("memory ack rose without req");
      err_cnt++;
   end
   a_cr_ack: assert property (ack_needs_req(cr_req_i, cr_ack_i))
   else
   begin
      $error("config ack rose without req");
      err_cnt++;
   end
   a_ld_ack: assert property (ack_needs_req(ld_req_i, ld_ack_i))
   else
   begin
      $error("loader ack rose without req");
      err_cnt++;
   end

   a_host_req: assert property (req_held_to_ack(host_req_i, host_ack_i))
   else
   begin
      $error("host req fell before ack");
      err_cnt++;
   end
   a_mem_req: assert property (req_held_to_ack(mem_req_i, mem_ack_i))
   else
   begin
      $error("memory req fell before ack");
      err_cnt++;
   end
   a_cr_req: assert property (req_held_to_ack(cr_req_i, cr_ack_i))
   else
   begin
      $error("config req fell before ack");
      err_cnt++;
   end
   a_ld_req: assert property (req_held_to_ack(ld_req_i, ld_ack_i))
   else
   begin
      $error("loader req fell before ack");
      err_cnt++;
   end

   a_host_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      (host_req_i && $past(host_req_i)) |->
         ($stable(host_op_i) && $stable(host_addr_i) && $stable(host_wdata_i)))
   else
   begin
      $error("host command changed while req high");
      err_cnt++;
   end
   a_ld_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      (ld_req_i && $past(ld_req_i)) |-> ($stable(ld_addr_i) && $stable(ld_wdata_i)))
   else
   begin
      $error("loader command changed while req high");
      err_cnt++;
   end

   a_done_held: assert property (@(posedge clk_i) disable iff (rst_i) !$fell(done_i))
   else
   begin
      $error("done fell after rising");
      err_cnt++;
   end

endmodule

bind boot_top boot_sva i_sva
  (.clk_i(clk_i), .rst_i(rst_i),
   .host_req_i(host_req_i), .host_op_i(host_op_i), .host_addr_i(host_addr_i),
   .host_wdata_i(host_wdata_i), .host_ack_i(host_ack_o), .done_i(done_o),
   .mem_req_i(mem_req), .mem_ack_i(mem_ack), .cr_req_i(cr_req), .cr_ack_i(cr_ack),
   .ld_req_i(ld_req), .ld_ack_i(ld_ack), .ld_addr_i(ld_addr), .ld_wdata_i(ld_wdata));

/* design/boot_top.sv */
/*
 * Boot-load subsystem top
 * Host command port into the sequencer, the loader and the
 * router, which reach the boot memory and the config registers.
 */
`timescale 1ns/1ns
`include "boot_settings.svh"

module boot_top
  (input  logic              clk_i,
   input  logic              rst_i,
   input  logic              host_req_i,
   input  boot_pkg::io_op_e  host_op_i,
   input  boot_pkg::addr_t   host_addr_i,
   input  boot_pkg::word_t   host_wdata_i,
   output logic              host_ack_o,
   output boot_pkg::word_t   host_rdata_o,
   output logic              done_o,
   output logic              freeze_o,
   output boot_pkg::word_t   core_id_o,
   output boot_pkg::word_t   boot_pc_o
   );

   import boot_pkg::*;

   logic                        host_we;
   logic                        rt_req, rt_ack, src_sel;
   word_t                       rt_rdata;
   logic                        cfg_start, cfg_done;
   logic                        ld_req, ld_we, ld_ack;
   addr_t                       ld_addr;
   word_t                       ld_wdata;
   logic                        mem_req, mem_we, mem_ack;
   logic [`BOOT_MEM_IDX_W-1:0]  mem_idx;
   word_t                       mem_wdata, mem_rdata;
   logic                        cr_req, cr_we, cr_ack;
   logic [`BOOT_CFG_OFF_W-1:0]  cr_off;
   word_t                       cr_wdata, cr_rdata;

   assign host_we = (host_op_i == OP_WRITE);

   boot_sequencer i_seq
     (.clk_i(clk_i), .rst_i(rst_i),
      .host_req_i(host_req_i), .host_op_i(host_op_i),
      .host_ack_o(host_ack_o), .host_rdata_o(host_rdata_o),
      .rt_req_o(rt_req), .src_sel_o(src_sel),
      .rt_ack_i(rt_ack), .rt_rdata_i(rt_rdata),
      .cfg_start_o(cfg_start), .cfg_done_i(cfg_done), .done_o(done_o));

   cfg_loader i_loader
     (.clk_i(clk_i), .rst_i(rst_i),
      .cfg_start_i(cfg_start), .cfg_done_o(cfg_done),
      .req_o(ld_req), .we_o(ld_we), .addr_o(ld_addr),
      .wdata_o(ld_wdata), .ack_i(ld_ack));

   io_router i_router
     (.clk_i(clk_i), .rst_i(rst_i), .src_sel_i(src_sel),
      .host_req_i(rt_req), .host_we_i(host_we), .host_addr_i(host_addr_i),
      .host_wdata_i(host_wdata_i), .host_ack_o(rt_ack), .host_rdata_o(rt_rdata),
      .req_i(ld_req), .we_i(ld_we), .addr_i(ld_addr), .wdata_i(ld_wdata),
      .ack_o(ld_ack),
      .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_idx_o(mem_idx),
      .mem_wdata_o(mem_wdata), .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata),
      .cr_req_o(cr_req), .cr_we_o(cr_we), .cr_off_o(cr_off),
      .cr_wdata_o(cr_wdata), .cr_ack_i(cr_ack), .cr_rdata_i(cr_rdata));

   boot_mem i_mem
     (.clk_i(clk_i), .rst_i(rst_i),
      .req_i(mem_req), .we_i(mem_we), .idx_i(mem_idx), .wdata_i(mem_wdata),
      .ack_o(mem_ack), .rdata_o(mem_rdata));

   cfg_regs i_cfg
     (.clk_i(clk_i), .rst_i(rst_i),
      .req_i(cr_req), .we_i(cr_we), .off_i(cr_off), .wdata_i(cr_wdata),
      .ack_o(cr_ack), .rdata_o(cr_rdata),
      .freeze_o(freeze_o), .core_id_o(core_id_o), .boot_pc_o(boot_pc_o));

endmodule

/* design/cfg_regs.sv */
/*
 * Config registers
 * Freeze, core id and boot PC with req/ack read and write access.
 * Unmapped offsets drop writes and read as zero.
 */
`timescale 1ns/1ns
`include "boot_settings.svh"

module cfg_regs
  (input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        req_i,
   input  logic                        we_i,
   input  logic [`BOOT_CFG_OFF_W-1:0]  off_i,
   input  boot_pkg::word_t             wdata_i,
   output logic                        ack_o,
   output boot_pkg::word_t             rdata_o,
   output logic                        freeze_o,
   output boot_pkg::word_t             core_id_o,
   output boot_pkg::word_t             boot_pc_o
   );

   import boot_pkg::*;

   logic  ack_q;
   logic  freeze_q;
   word_t core_id_q;
   word_t boot_pc_q;
   word_t rdata_q;
   word_t rd_sel;
   logic  accept;

   assign accept = req_i && !ack_q;

   always_comb
   begin
      case (off_i)
         CFG_FREEZE:  rd_sel = word_t'(freeze_q);
         CFG_CORE_ID: rd_sel = core_id_q;
         CFG_BOOT_PC: rd_sel = boot_pc_q;
         default:     rd_sel = '0;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         ack_q     <= 1'b0;
         freeze_q  <= 1'b1;
         core_id_q <= '0;
         boot_pc_q <= '0;
      end
      else if (accept)
      begin
         ack_q <= 1'b1;
         if (we_i)
         begin
            case (off_i)
               CFG_FREEZE:  freeze_q  <= wdata_i[0];
               CFG_CORE_ID: core_id_q <= wdata_i;
               CFG_BOOT_PC: boot_pc_q <= wdata_i;
               default:     ;
            endcase
         end
      end
      else if (!req_i)
         ack_q <= 1'b0;
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
         rdata_q <= rd_sel;
   end

   assign ack_o     = ack_q;
   assign rdata_o   = rdata_q;
   assign freeze_o  = freeze_q;
   assign core_id_o = core_id_q;
   assign boot_pc_o = boot_pc_q;

endmodule

/* design/boot_mem.sv */
/*
 * Boot memory
 * Word-wide memory that clears itself one word per cycle after
 * reset, then serves one read or write per req/ack cycle.
 */
`timescale 1ns/1ns
`include "boot_settings.svh"

module boot_mem
  (input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        req_i,
   input  logic                        we_i,
   input  logic [`BOOT_MEM_IDX_W-1:0]  idx_i,
   input  boot_pkg::word_t             wdata_i,
   output logic                        ack_o,
   output boot_pkg::word_t             rdata_o
   );

   import boot_pkg::*;

   word_t                     mem_q [`BOOT_MEM_WORDS];
   logic [`BOOT_MEM_IDX_W:0]  clr_cnt_q;
   logic                      clr_busy;
   logic                      ack_q;
   word_t                     rdata_q;
   logic                      accept;

   // Counter top bit set once every word is cleared
   assign clr_busy = !clr_cnt_q[`BOOT_MEM_IDX_W];
   assign accept   = req_i && !ack_q && !clr_busy;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         clr_cnt_q <= '0;
      else if (clr_busy)
         clr_cnt_q <= clr_cnt_q + 1'b1;
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         ack_q <= 1'b0;
      else if (accept)
         ack_q <= 1'b1;
      else if (!req_i)
         ack_q <= 1'b0;
   end

   always_ff @(posedge clk_i)
   begin
      if (clr_busy)
         mem_q[clr_cnt_q[`BOOT_MEM_IDX_W-1:0]] <= '0;
      else if (accept && we_i)
         mem_q[idx_i] <= wdata_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
         rdata_q <= mem_q[idx_i];
   end

   assign ack_o   = ack_q;
   assign rdata_o = rdata_q;

endmodule

/* design/io_router.sv */
/*
 * IO router
 * Picks the host or the config loader as source, registers the
 * request, decodes memory or config space from the top address
 * bit and runs the four-phase handshake toward that target.
 */
`timescale 1ns/1ns
`include "boot_settings.svh"

module io_router
  (input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        src_sel_i,
   input  logic                        host_req_i,
   input  logic                        host_we_i,
   input  boot_pkg::addr_t             host_addr_i,
   input  boot_pkg::word_t             host_wdata_i,
   output logic                        host_ack_o,
   output boot_pkg::word_t             host_rdata_o,
   input  logic                        req_i,
   input  logic                        we_i,
   input  boot_pkg::addr_t             addr_i,
   input  boot_pkg::word_t             wdata_i,
   output logic                        ack_o,
   output logic                        mem_req_o,
   output logic                        mem_we_o,
   output logic [`BOOT_MEM_IDX_W-1:0]  mem_idx_o,
   output boot_pkg::word_t             mem_wdata_o,
   input  logic                        mem_ack_i,
   input  boot_pkg::word_t             mem_rdata_i,
   output logic                        cr_req_o,
   output logic                        cr_we_o,
   output logic [`BOOT_CFG_OFF_W-1:0]  cr_off_o,
   output boot_pkg::word_t             cr_wdata_o,
   input  logic                        cr_ack_i,
   input  boot_pkg::word_t             cr_rdata_i
   );

   import boot_pkg::*;

   typedef enum logic [1:0] {
      RT_IDLE = 2'd0,
      RT_REQ  = 2'd1,
      RT_ACK  = 2'd2
   } rt_state_e;

   rt_state_e state_q;
   logic      src_q;
   logic      tgt_cfg_q;
   logic      we_q;
   addr_t     addr_q;
   word_t     wdata_q;
   word_t     rdata_q;
   logic      sel_req;
   logic      src_req;
   logic      tgt_ack;

   assign sel_req = src_sel_i ? req_i : host_req_i;
   assign src_req = src_q ? req_i : host_req_i;
   assign tgt_ack = tgt_cfg_q ? cr_ack_i : mem_ack_i;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_q   <= RT_IDLE;
         src_q     <= 1'b0;
         tgt_cfg_q <= 1'b0;
      end
      else
      begin
         case (state_q)
            RT_IDLE:
            begin
               if (sel_req)
               begin
                  src_q     <= src_sel_i;
                  tgt_cfg_q <= src_sel_i ? addr_i[`BOOT_ADDR_W-1]
                                         : host_addr_i[`BOOT_ADDR_W-1];
                  state_q   <= RT_REQ;
               end
            end
            RT_REQ:
            begin
               if (tgt_ack)
                  state_q <= RT_ACK;
            end
            RT_ACK:
            begin
               // Source released and target idle again
               if (!src_req && !tgt_ack)
                  state_q <= RT_IDLE;
            end
            default:
            begin
               state_q <= RT_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (state_q == RT_IDLE && sel_req)
      begin
         we_q    <= src_sel_i ? we_i : host_we_i;
         addr_q  <= src_sel_i ? addr_i : host_addr_i;
         wdata_q <= src_sel_i ? wdata_i : host_wdata_i;
      end
      if (state_q == RT_REQ && tgt_ack)
         rdata_q <= tgt_cfg_q ? cr_rdata_i : mem_rdata_i;
   end

   // Memory index wraps on the low address bits
   assign mem_req_o   = (state_q == RT_REQ) && !tgt_cfg_q;
   assign mem_we_o    = we_q;
   assign mem_idx_o   = addr_q[`BOOT_MEM_IDX_W-1:0];
   assign mem_wdata_o = wdata_q;

   assign cr_req_o   = (state_q == RT_REQ) && tgt_cfg_q;
   assign cr_we_o    = we_q;
   assign cr_off_o   = addr_q[`BOOT_CFG_OFF_W-1:0];
   assign cr_wdata_o = wdata_q;

   assign host_ack_o   = (state_q == RT_ACK) && !src_q;
   assign ack_o        = (state_q == RT_ACK) && src_q;
   assign host_rdata_o = rdata_q;

endmodule

/* design/cfg_loader.sv */
/*
 * Config loader
 * Writes core id, boot PC and finally freeze = 0 into config
 * space, one full four-phase cycle per write, then reports done.
 */
`timescale 1ns/1ns
`include "boot_settings.svh"

module cfg_loader
  (input  logic             clk_i,
   input  logic             rst_i,
   input  logic             cfg_start_i,
   output logic             cfg_done_o,
   output logic             req_o,
   output logic             we_o,
   output boot_pkg::addr_t  addr_o,
   output boot_pkg::word_t  wdata_o,
   input  logic             ack_i
   );

   import boot_pkg::*;

   typedef enum logic [1:0] {
      LD_IDLE = 2'd0,
      LD_REQ  = 2'd1,
      LD_DROP = 2'd2,
      LD_DONE = 2'd3
   } ld_state_e;

   ld_state_e                   state_q;
   logic [1:0]                  step_q;
   logic [`BOOT_CFG_OFF_W-1:0]  off;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_q <= LD_IDLE;
         step_q  <= 2'd0;
      end
      else
      begin
         case (state_q)
            LD_IDLE:
            begin
               step_q <= 2'd0;
               if (cfg_start_i)
                  state_q <= LD_REQ;
            end
            LD_REQ:
            begin
               if (ack_i)
                  state_q <= LD_DROP;
            end
            LD_DROP:
            begin
               // Next write only once ack is low again
               if (!ack_i)
               begin
                  if (step_q == 2'd2)
                     state_q <= LD_DONE;
                  else
                  begin
                     step_q  <= step_q + 2'd1;
                     state_q <= LD_REQ;
                  end
               end
            end
            LD_DONE:
            begin
               if (!cfg_start_i)
                  state_q <= LD_IDLE;
            end
            default:
            begin
               state_q <= LD_IDLE;
            end
         endcase
      end
   end

   // Write sequence, freeze cleared last
   always_comb
   begin
      case (step_q)
         2'd0:
         begin
            off     = CFG_CORE_ID;
            wdata_o = word_t'(`BOOT_CORE_ID);
         end
         2'd1:
         begin
            off     = CFG_BOOT_PC;
            wdata_o = word_t'(`BOOT_PC);
         end
         default:
         begin
            off     = CFG_FREEZE;
            wdata_o = '0;
         end
      endcase
   end

   assign addr_o     = {1'b1, off};
   assign req_o      = (state_q == LD_REQ);
   assign we_o       = (state_q == LD_REQ);
   assign cfg_done_o = (state_q == LD_DONE);

endmodule

/* design/boot_sequencer.sv */
/*
 * Boot sequencer
 * Owns the load, config and run phases. Passes host reads and
 * writes to the router, acknowledges FINISH itself, starts the
 * config loader and selects which source drives the router.
 */
`timescale 1ns/1ns

module boot_sequencer
  (input  logic              clk_i,
   input  logic              rst_i,
   input  logic              host_req_i,
   input  boot_pkg::io_op_e  host_op_i,
   output logic              host_ack_o,
   output boot_pkg::word_t   host_rdata_o,
   output logic              rt_req_o,
   output logic              src_sel_o,
   input  logic              rt_ack_i,
   input  boot_pkg::word_t   rt_rdata_i,
   output logic              cfg_start_o,
   input  logic              cfg_done_i,
   output logic              done_o
   );

   import boot_pkg::*;

   boot_state_e state_q;
   logic        fin_ack_q;
   logic        fin_go;

   // FINISH is served here, never in the config phase
   assign fin_go = host_req_i && (host_op_i == OP_FINISH) && (state_q != ST_CFG)
                   && !fin_ack_q;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_q   <= ST_LOAD;
         fin_ack_q <= 1'b0;
      end
      else
      begin
         if (fin_go)
            fin_ack_q <= 1'b1;
         else if (!host_req_i)
            fin_ack_q <= 1'b0;

         case (state_q)
            ST_LOAD:
            begin
               if (fin_go)
                  state_q <= ST_CFG;
            end
            ST_CFG:
            begin
               if (cfg_done_i)
                  state_q <= ST_RUN;
            end
            ST_RUN:
            begin
               state_q <= ST_RUN;
            end
            default:
            begin
               state_q <= ST_LOAD;
            end
         endcase
      end
   end

   // Host held off while the loader owns the router
   assign rt_req_o = host_req_i && (host_op_i != OP_FINISH) && (state_q != ST_CFG);

   assign host_ack_o   = fin_ack_q | rt_ack_i;
   assign host_rdata_o = rt_rdata_i;

   assign src_sel_o   = (state_q == ST_CFG);
   assign cfg_start_o = (state_q == ST_CFG);
   assign done_o      = (state_q == ST_RUN);

endmodule

/* design/boot_pkg.sv */
/*
 * Boot-load package
 * Word and address types, the host opcodes, the boot
 * sequencer states and the config register offsets.
 */
`include "boot_settings.svh"

package boot_pkg;

   typedef logic [`BOOT_DATA_W-1:0] word_t;
   typedef logic [`BOOT_ADDR_W-1:0] addr_t;

   typedef enum logic [1:0] {
      OP_WRITE  = 2'd0,
      OP_READ   = 2'd1,
      OP_FINISH = 2'd2
   } io_op_e;

   typedef enum logic [1:0] {
      ST_LOAD = 2'd0,
      ST_CFG  = 2'd1,
      ST_RUN  = 2'd2
   } boot_state_e;

   // Config space offsets
   localparam logic [`BOOT_CFG_OFF_W-1:0] CFG_FREEZE  = 'd0;
   localparam logic [`BOOT_CFG_OFF_W-1:0] CFG_CORE_ID = 'd1;
   localparam logic [`BOOT_CFG_OFF_W-1:0] CFG_BOOT_PC = 'd2;

endpackage

/* boot_settings.svh */
/*
 * Boot-load subsystem settings
 * Widths, memory depth and the values that the config loader
 * writes during the boot sequence.
 */
`ifndef BOOT_SETTINGS_SVH
`define BOOT_SETTINGS_SVH

`define BOOT_DATA_W     32
`define BOOT_ADDR_W     12
`define BOOT_MEM_WORDS  256

// Index and offset widths derived from the above
`define BOOT_MEM_IDX_W  8
`define BOOT_CFG_OFF_W  (`BOOT_ADDR_W-1)

`define BOOT_CORE_ID    3
`define BOOT_PC         32'h0000_0100

`endif
